/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = rv_ctrl_decoder_tb
FILELIST  = rv_ctrl_decoder.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/decode_output_stage.sv */
// Decode output stage, resolves branch direction, flags ebreak and registers the control word
module decode_output_stage (
    input  logic                            clk,
    input  logic                            rst,        // Sync, active high
    input  logic [rv_ctrl_pkg::INST_W-1:0]  inst,
    input  rv_ctrl_pkg::ctrl_word_t         lut_ctrl,   // Static decode from the table
    input  logic                            br_eq,      // rs1 == rs2
    input  logic                            br_lt,      // rs1 < rs2 signed
    input  logic                            br_ltu,     // rs1 < rs2 unsigned
    output rv_ctrl_pkg::ctrl_word_t         ctrl,
    output logic                            is_ebreak
);
    import rv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       br_taken;
    ctrl_word_t ctrl_nxt;
    logic       ebreak_nxt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // Compare flag chosen by the branch type
    always_comb begin
        br_taken = 1'b0;
        if (opcode == OPC_BRANCH) begin
            case (funct3)
                F3_BEQ:  br_taken = br_eq;
                F3_BLT:  br_taken = br_lt;
                F3_BLTU: br_taken = br_ltu;
                default: br_taken = 1'b0;   // Table misses these anyway
            endcase
        end
    end

    always_comb begin
        ctrl_nxt = lut_ctrl;
        if (br_taken) begin
            ctrl_nxt.pc_sel = PC_BRANCH;    // Override sequential PC
        end
    end

    assign ebreak_nxt = (inst == INST_EBREAK);  // Exact encoding only

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl      <= '0;                // PC_SEQ, no writes
            is_ebreak <= 1'b0;
        end else begin
            ctrl      <= ctrl_nxt;
            is_ebreak <= ebreak_nxt;
        end
    end

endmodule

/* rtl/inst_key_former.sv */
// Instruction key former, packs opcode, funct3 and funct7 into a normalised lookup key
module inst_key_former (
    input  logic [rv_ctrl_pkg::INST_W-1:0] inst,   // Raw instruction
    output logic [rv_ctrl_pkg::KEY_W-1:0]  key     // {opcode, funct3, funct7}
);
    import rv_ctrl_pkg::*;

    localparam logic [6:0] F7_MISS = 7'b1101111;   // Matches no table entry

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            OPC_JALR: begin
                if (funct3 == 3'b000)
                    key = {opcode, funct3, F7_BASE};   // funct7 is offset bits
                else
                    key = {opcode, funct3, F7_MISS};   // Reserved funct3
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b101)
                    key = {opcode, funct3, funct7};    // SRLI vs SRAI
                else
                    key = {opcode, funct3, F7_BASE};   // Upper bits are immediate
            end
            OPC_AUIPC, OPC_JAL: begin
                key = {opcode, 3'b000, F7_BASE};       // Whole upper field is immediate
            end
            OPC_BRANCH: begin
                // funct7 position holds branch offset bits, funct3 picks the compare
                key = {opcode, funct3, F7_BASE};
            end
            default: begin
                key = {opcode, funct3, funct7};        // R-type, system, unknown
            end
        endcase
    end

endmodule

/* rtl/key_lut_mux.sv */
// Key-to-data lookup mux over a flat table of pairs, all-zero output when nothing matches
module key_lut_mux #(
    parameter int NR_KEY = 2,                       // Table entries
    parameter int KEY_W  = 1,
    parameter int DATA_W = 1
) (
    input  logic [KEY_W-1:0]                 key,
    input  logic [NR_KEY*(KEY_W+DATA_W)-1:0] lut,  // {key, data} pairs, entry 0 at LSB
    output logic [DATA_W-1:0]                data
);

    localparam int PAIR_W = KEY_W + DATA_W;

    logic [NR_KEY-1:0] hit;                         // One-hot when keys are unique

    always_comb begin
        for (int i = 0; i < NR_KEY; i++) begin
            hit[i] = (lut[i*PAIR_W+DATA_W +: KEY_W] == key);
        end
    end

    // AND-OR mux, a miss leaves every term zero
    always_comb begin
        data = '0;
        for (int i = 0; i < NR_KEY; i++) begin
            data = data | ({DATA_W{hit[i]}} & lut[i*PAIR_W +: DATA_W]);
        end
    end

endmodule

/* rtl/rv_ctrl_decoder.sv */
// RV32I control decoder top, key former and table lookup feeding a registered output stage
module rv_ctrl_decoder #(
    parameter int NR_KEY = rv_ctrl_pkg::NR_KEY,     // Table entries
    parameter int KEY_W  = rv_ctrl_pkg::KEY_W       // Lookup key width
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [rv_ctrl_pkg::INST_W-1:0] inst,
    input  logic                           br_eq,
    input  logic                           br_lt,
    input  logic                           br_ltu,
    output rv_ctrl_pkg::ctrl_word_t        ctrl,     // One cycle after inst
    output logic                           is_ebreak
);
    import rv_ctrl_pkg::*;

    logic [KEY_W-1:0] key;
    ctrl_word_t       lut_ctrl;

    inst_key_former inst_key_former_i (
        .inst (inst),
        .key  (key)
    );

    key_lut_mux #(
        .NR_KEY (NR_KEY),
        .KEY_W  (KEY_W),
        .DATA_W (CTRL_W)
    ) key_lut_mux_i (
        .key  (key),
        .lut  (CTRL_LUT),       // Decode table from the package
        .data (lut_ctrl)
    );

    decode_output_stage decode_output_stage_i (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .lut_ctrl  (lut_ctrl),
        .br_eq     (br_eq),
        .br_lt     (br_lt),
        .br_ltu    (br_ltu),
        .ctrl      (ctrl),
        .is_ebreak (is_ebreak)
    );

endmodule

/* rtl/rv_ctrl_pkg.sv */
// RV32I control decoder package with field widths, encodings, control word and decode table
package rv_ctrl_pkg;

    localparam int INST_W   = 32;               // Instruction width
    localparam int KEY_W    = 17;               // opcode + funct3 + funct7
    localparam int NR_KEY   = 26;               // Decoded instructions
    localparam int ALU_OP_W = 5;
    localparam int SEL_W    = 2;                // Operand and write-back selects
    localparam int PC_SEL_W = 3;

    typedef struct packed {
        logic [ALU_OP_W-1:0] alu_op;            // ALU operation
        logic [SEL_W-1:0]    op1_sel;           // ALU operand 1 source
        logic [SEL_W-1:0]    op2_sel;           // ALU operand 2 source
        logic [PC_SEL_W-1:0] pc_sel;            // Next PC source
        logic                rf_we;             // Register file write
        logic                mem_en;            // Data memory access
        logic                mem_wen;           // Data memory write
        logic [SEL_W-1:0]    wb_sel;            // Write-back source
    } ctrl_word_t;

    localparam int CTRL_W = $bits(ctrl_word_t); // 17 bits

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;    // Branch funct3 values
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    localparam logic [PC_SEL_W-1:0] PC_SEQ    = 3'b000; // pc + 4
    localparam logic [PC_SEL_W-1:0] PC_JALR   = 3'b001;
    localparam logic [PC_SEL_W-1:0] PC_BRANCH = 3'b010;
    localparam logic [PC_SEL_W-1:0] PC_JAL    = 3'b011;

    localparam logic [SEL_W-1:0] OP1_RS1 = 2'b00;
    localparam logic [SEL_W-1:0] OP1_PC  = 2'b01;
    localparam logic [SEL_W-1:0] OP2_IMM = 2'b01;
    localparam logic [SEL_W-1:0] OP2_RS2 = 2'b11;
    localparam logic [SEL_W-1:0] WB_NONE = 2'b00;
    localparam logic [SEL_W-1:0] WB_PC4  = 2'b01; // Link address
    localparam logic [SEL_W-1:0] WB_ALU  = 2'b10;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 5'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 5'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 5'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 5'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 5'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 5'd5;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 5'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 5'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 5'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 5'd9;

    localparam logic [INST_W-1:0] INST_EBREAK = 32'h00100073;

    // Builds a control word, this core has no loads or stores yet
    function automatic ctrl_word_t mk_ctrl(input logic [ALU_OP_W-1:0] alu_op,
                                           input logic [SEL_W-1:0] op1_sel,
                                           input logic [SEL_W-1:0] op2_sel,
                                           input logic [PC_SEL_W-1:0] pc_sel,
                                           input logic rf_we,
                                           input logic [SEL_W-1:0] wb_sel);
        ctrl_word_t c;
        c         = '0;
        c.alu_op  = alu_op;
        c.op1_sel = op1_sel;
        c.op2_sel = op2_sel;
        c.pc_sel  = pc_sel;
        c.rf_we   = rf_we;
        c.wb_sel  = wb_sel;
        return c;
    endfunction

    function automatic ctrl_word_t r_ctrl(input logic [ALU_OP_W-1:0] op); // rs1 op rs2
        return mk_ctrl(op, OP1_RS1, OP2_RS2, PC_SEQ, 1'b1, WB_ALU);
    endfunction

    function automatic ctrl_word_t i_ctrl(input logic [ALU_OP_W-1:0] op); // rs1 op imm
        return mk_ctrl(op, OP1_RS1, OP2_IMM, PC_SEQ, 1'b1, WB_ALU);
    endfunction

    localparam ctrl_word_t CTRL_IDLE = mk_ctrl(ALU_ADD, OP1_RS1, 2'b00, PC_SEQ, 1'b0, WB_NONE);

    // Key / control word pairs, MSB pair first
    localparam logic [NR_KEY*(KEY_W+CTRL_W)-1:0] CTRL_LUT = {
        {OPC_OP, 3'b000, F7_BASE},     r_ctrl(ALU_ADD),     // ADD
        {OPC_OP, 3'b000, F7_ALT},      r_ctrl(ALU_SUB),     // SUB
        {OPC_OP, 3'b001, F7_BASE},     r_ctrl(ALU_SLL),     // SLL
        {OPC_OP, 3'b010, F7_BASE},     r_ctrl(ALU_SLT),     // SLT
        {OPC_OP, 3'b011, F7_BASE},     r_ctrl(ALU_SLTU),    // SLTU
        {OPC_OP, 3'b100, F7_BASE},     r_ctrl(ALU_XOR),     // XOR
        {OPC_OP, 3'b101, F7_BASE},     r_ctrl(ALU_SRL),     // SRL
        {OPC_OP, 3'b101, F7_ALT},      r_ctrl(ALU_SRA),     // SRA
        {OPC_OP, 3'b110, F7_BASE},     r_ctrl(ALU_OR),      // OR
        {OPC_OP, 3'b111, F7_BASE},     r_ctrl(ALU_AND),     // AND
        {OPC_OP_IMM, 3'b000, F7_BASE}, i_ctrl(ALU_ADD),     // ADDI
        {OPC_OP_IMM, 3'b010, F7_BASE}, i_ctrl(ALU_SLT),     // SLTI
        {OPC_OP_IMM, 3'b011, F7_BASE}, i_ctrl(ALU_SLTU),    // SLTIU
        {OPC_OP_IMM, 3'b100, F7_BASE}, i_ctrl(ALU_XOR),     // XORI
        {OPC_OP_IMM, 3'b110, F7_BASE}, i_ctrl(ALU_OR),      // ORI
        {OPC_OP_IMM, 3'b111, F7_BASE}, i_ctrl(ALU_AND),     // ANDI
        {OPC_OP_IMM, 3'b001, F7_BASE}, i_ctrl(ALU_SLL),     // SLLI
        {OPC_OP_IMM, 3'b101, F7_BASE}, i_ctrl(ALU_ADD),     // SRLI, legacy ALU code
        {OPC_OP_IMM, 3'b101, F7_ALT},  i_ctrl(ALU_SUB),     // SRAI, legacy ALU code
        {OPC_BRANCH, F3_BEQ, F7_BASE}, CTRL_IDLE,           // BEQ, taken PC added later
        {OPC_BRANCH, F3_BLT, F7_BASE}, CTRL_IDLE,           // BLT
        {OPC_BRANCH, F3_BLTU, F7_BASE}, CTRL_IDLE,          // BLTU
        {OPC_JAL, 3'b000, F7_BASE},
        mk_ctrl(ALU_ADD, OP1_RS1, 2'b00, PC_JAL, 1'b1, WB_PC4),      // JAL
        {OPC_AUIPC, 3'b000, F7_BASE},
        mk_ctrl(ALU_ADD, OP1_PC, 2'b00, PC_SEQ, 1'b1, WB_ALU),       // AUIPC
        {OPC_JALR, 3'b000, F7_BASE},
        mk_ctrl(ALU_ADD, OP1_RS1, OP2_IMM, PC_JALR, 1'b1, WB_PC4),   // JALR
        {OPC_SYSTEM, 3'b000, F7_BASE}, CTRL_IDLE            // EBREAK
    };

endpackage

/* rv_ctrl_decoder.f */
rtl/rv_ctrl_pkg.sv
rtl/inst_key_former.sv
rtl/key_lut_mux.sv
rtl/decode_output_stage.sv
rtl/rv_ctrl_decoder.sv
test/rv_ctrl_decoder_props.sv
test/rv_ctrl_decoder_tb.sv

/* test/rv_ctrl_decoder_props.sv */
// Bound assertions on the decoder outputs, reset clearing and control word consistency
module rv_ctrl_decoder_props (
    input logic                    clk,
    input logic                    rst,
    input rv_ctrl_pkg::ctrl_word_t ctrl,
    input logic                    is_ebreak
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_ctrl_pkg::*;

    // Output register cleared one edge after rst
    ctrl_zero_after_rst: assert property (@(posedge clk) rst |=> (ctrl == '0 && !is_ebreak))
        else $error("ctrl word or is_ebreak not cleared after reset");

    // No loads or stores in this core
    no_mem_access: assert property (@(posedge clk) disable iff (rst) !ctrl.mem_en && !ctrl.mem_wen)
        else $error("memory enable raised by the decoder");

    ebreak_no_write: assert property (@(posedge clk) disable iff (rst) is_ebreak |-> !ctrl.rf_we)
        else $error("register write together with ebreak");

endmodule

/* test/rv_ctrl_decoder_tb.sv */
// Testbench for the RV32I control decoder with file vectors and random unknown opcodes
module rv_ctrl_decoder_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_ctrl_pkg::*;

    localparam int N_VEC     = 34;                  // Lines in the stim file
    localparam int N_COL     = 11;                  // Words per vector
    localparam int N_RAND    = 16;                  // Random unknown opcodes
    localparam int CYC_LIMIT = N_VEC + N_RAND + 20;
    localparam logic [31:0] SEED = 32'd6264;

    logic              clk;
    logic              rst;
    logic [INST_W-1:0] inst;
    logic              br_eq;
    logic              br_lt;
    logic              br_ltu;
    ctrl_word_t        dut_ctrl;
    logic              dut_ebreak;

    logic [31:0] stim_mem [0:N_VEC*N_COL-1];
    logic [31:0] lcg_state;
    int          err_cnt;
    int          check_cnt;
    int          cycle_cnt = 0;

    rv_ctrl_decoder #(
        .NR_KEY (NR_KEY),
        .KEY_W  (KEY_W)
    ) rv_ctrl_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .br_eq     (br_eq),
        .br_lt     (br_lt),
        .br_ltu    (br_ltu),
        .ctrl      (dut_ctrl),
        .is_ebreak (dut_ebreak)
    );

    bind rv_ctrl_decoder rv_ctrl_decoder_props props_i (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .is_ebreak (is_ebreak)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                           // 8 ns period

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYC_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic opcode_known(input logic [6:0] op);
        return (op == OPC_OP) || (op == OPC_OP_IMM) || (op == OPC_BRANCH) || (op == OPC_JAL)
            || (op == OPC_JALR) || (op == OPC_AUIPC) || (op == OPC_SYSTEM);
    endfunction

    // Expected word from columns 2 to 9
    function automatic ctrl_word_t vec_ctrl(input int base);
        ctrl_word_t c;
        c.alu_op  = stim_mem[base+2][ALU_OP_W-1:0];
        c.op1_sel = stim_mem[base+3][SEL_W-1:0];
        c.op2_sel = stim_mem[base+4][SEL_W-1:0];
        c.pc_sel  = stim_mem[base+5][PC_SEL_W-1:0];
        c.rf_we   = stim_mem[base+6][0];
        c.mem_en  = stim_mem[base+7][0];
        c.mem_wen = stim_mem[base+8][0];
        c.wb_sel  = stim_mem[base+9][SEL_W-1:0];
        return c;
    endfunction

    task automatic report_value(input string field, input logic [31:0] got,
                                input logic [31:0] want, input string tag);
        $display("ERR %0d ns: %s %s got %0h expected %0h", $time, tag, field, got, want);
        err_cnt++;
    endtask

    task automatic check_outputs(input ctrl_word_t exp, input logic exp_ebreak, input string tag);
        check_cnt++;
        if (dut_ctrl.alu_op !== exp.alu_op)
            report_value("alu_op", 32'(dut_ctrl.alu_op), 32'(exp.alu_op), tag);
        if (dut_ctrl.op1_sel !== exp.op1_sel)
            report_value("op1_sel", 32'(dut_ctrl.op1_sel), 32'(exp.op1_sel), tag);
        if (dut_ctrl.op2_sel !== exp.op2_sel)
            report_value("op2_sel", 32'(dut_ctrl.op2_sel), 32'(exp.op2_sel), tag);
        if (dut_ctrl.pc_sel !== exp.pc_sel)
            report_value("pc_sel", 32'(dut_ctrl.pc_sel), 32'(exp.pc_sel), tag);
        if (dut_ctrl.rf_we !== exp.rf_we)
            report_value("rf_we", 32'(dut_ctrl.rf_we), 32'(exp.rf_we), tag);
        if (dut_ctrl.mem_en !== exp.mem_en)
            report_value("mem_en", 32'(dut_ctrl.mem_en), 32'(exp.mem_en), tag);
        if (dut_ctrl.mem_wen !== exp.mem_wen)
            report_value("mem_wen", 32'(dut_ctrl.mem_wen), 32'(exp.mem_wen), tag);
        if (dut_ctrl.wb_sel !== exp.wb_sel)
            report_value("wb_sel", 32'(dut_ctrl.wb_sel), 32'(exp.wb_sel), tag);
        if (dut_ebreak !== exp_ebreak)
            report_value("is_ebreak", 32'(dut_ebreak), 32'(exp_ebreak), tag);
    endtask

    task automatic drive(input logic [31:0] i, input logic [2:0] flags);
        inst   = i;
        br_eq  = flags[2];
        br_lt  = flags[1];
        br_ltu = flags[0];
    endtask

    // Checks at each falling edge the vector driven one cycle earlier
    task automatic run_tests();
        ctrl_word_t  exp_c;
        logic        exp_e;
        logic        pend;
        logic [6:0]  rnd_op;
        string       tag;
        repeat (2) @(posedge clk);
        @(negedge clk);
        drive(32'h008000EF, 3'b111);                // JAL decodes to a non-zero word
        @(posedge clk);
        @(negedge clk);
        check_outputs('0, 1'b0, "reset");           // Still in reset here
        rst  = 1'b0;
        pend = 1'b0;
        for (int v = 0; v < N_VEC; v++) begin
            @(negedge clk);
            if (pend)
                check_outputs(exp_c, exp_e, tag);
            drive(stim_mem[v*N_COL], stim_mem[v*N_COL+1][2:0]);
            exp_c = vec_ctrl(v * N_COL);
            exp_e = stim_mem[v*N_COL+10][0];
            tag   = $sformatf("vec %0d", v);
            pend  = 1'b1;
        end
        for (int r = 0; r < N_RAND; r++) begin
            @(negedge clk);
            check_outputs(exp_c, exp_e, tag);
            lcg_state = lcg_next(lcg_state);
            rnd_op    = lcg_state[31:25];
            if (opcode_known(rnd_op))
                rnd_op[0] = 1'b0;                   // Every known opcode ends in 11
            lcg_state = lcg_next(lcg_state);
            drive({lcg_state[31:7], rnd_op}, lcg_state[10:8]);
            exp_c = '0;                             // Miss gives all zeros
            exp_e = 1'b0;
            tag   = $sformatf("rand %0d inst %08h", r, {lcg_state[31:7], rnd_op});
        end
        @(negedge clk);
        check_outputs(exp_c, exp_e, tag);
    endtask

    initial begin
        rst       = 1'b1;
        err_cnt   = 0;
        check_cnt = 0;
        lcg_state = SEED;
        drive(INST_EBREAK, 3'b111);                 // Raises is_ebreak unless reset holds it
        for (int a = 0; a < N_VEC * N_COL; a++)
            stim_mem[a] = ~32'(a);                  // Marks words the file did not fill
        $readmemh("test/rv_ctrl_stim.txt", stim_mem);
        if (stim_mem[N_VEC*N_COL-1] == ~32'(N_VEC*N_COL-1)) begin
            $display("Stimulus file test/rv_ctrl_stim.txt missing or shorter than %0d vectors",
                     N_VEC);
            $display("TEST FAILED");
            $finish;
        end else begin
            run_tests();
            $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
            if (err_cnt == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* test/rv_ctrl_stim.txt */
// inst     fl alu o1 o2 pc we me mw wb eb    fl = {br_eq, br_lt, br_ltu}
// Columns after fl are the expected ctrl fields and is_ebreak, all hex
002081B3    7  00  0  3  0  1  0  0  2  0     // ADD, flags ignored
402081B3    0  01  0  3  0  1  0  0  2  0     // SUB
002091B3    0  07  0  3  0  1  0  0  2  0     // SLL
0020A1B3    0  02  0  3  0  1  0  0  2  0     // SLT
0020B1B3    0  03  0  3  0  1  0  0  2  0     // SLTU
0020C1B3    4  04  0  3  0  1  0  0  2  0     // XOR
0020D1B3    0  08  0  3  0  1  0  0  2  0     // SRL
4020D1B3    0  09  0  3  0  1  0  0  2  0     // SRA
0020E1B3    0  05  0  3  0  1  0  0  2  0     // OR
0020F1B3    0  06  0  3  0  1  0  0  2  0     // AND
FFF08193    0  00  0  1  0  1  0  0  2  0     // ADDI -1
0050A193    0  02  0  1  0  1  0  0  2  0     // SLTI
8000B193    0  03  0  1  0  1  0  0  2  0     // SLTIU, imm top bit set
0F00C193    0  04  0  1  0  1  0  0  2  0     // XORI
1230E193    2  05  0  1  0  1  0  0  2  0     // ORI
FF00F193    0  06  0  1  0  1  0  0  2  0     // ANDI
00309193    0  07  0  1  0  1  0  0  2  0     // SLLI
0040D193    0  00  0  1  0  1  0  0  2  0     // SRLI, legacy ADD code
4040D193    0  01  0  1  0  1  0  0  2  0     // SRAI, legacy SUB code
00208463    4  00  0  0  2  0  0  0  0  0     // BEQ taken
FE208EE3    3  00  0  0  0  0  0  0  0  0     // BEQ not taken, other flags high
0020C463    2  00  0  0  2  0  0  0  0  0     // BLT taken
0020C463    5  00  0  0  0  0  0  0  0  0     // BLT not taken
0020E463    1  00  0  0  2  0  0  0  0  0     // BLTU taken
0020E463    6  00  0  0  0  0  0  0  0  0     // BLTU not taken
008000EF    0  00  0  0  3  1  0  0  1  0     // JAL
12345297    0  00  1  0  0  1  0  0  2  0     // AUIPC
010080E7    7  00  0  1  1  1  0  0  1  0     // JALR
010090E7    0  00  0  0  0  0  0  0  0  0     // JALR reserved funct3
00100073    7  00  0  0  0  0  0  0  0  1     // EBREAK
00000073    0  00  0  0  0  0  0  0  0  0     // ECALL
00002083    0  00  0  0  0  0  0  0  0  0     // Load opcode, not decoded
022081B3    0  00  0  0  0  0  0  0  0  0     // R-type funct7 01
402091B3    0  00  0  0  0  0  0  0  0  0     // SLL with alternate funct7
